/* dbg_pkg.sv */
/*
  Shared definitions for the debug unit: data and bus widths, the debug
  register map and the enums for host commands and controller states.
  Compile first; other files refer to it by scoped names only.
*/

`default_nettype none

package dbg_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // data path and debug bus address
  localparam int unsigned XLEN    = 32;
  localparam int unsigned PLEN    = 8;

  // shadow general registers
  localparam int unsigned NUM_GPR = 8;
  localparam int unsigned GPR_AW  = $clog2(NUM_GPR);

  //////////////////////////////
  // register map
  //////////////////////////////

  // gprs sit at 0 .. NUM_GPR-1
  localparam logic [PLEN-1:0] ADR_BP_ADDR  = 8'd8;
  // bit 0 enable, rest reads zero
  localparam logic [PLEN-1:0] ADR_BP_CTRL  = 8'd9;
  // read only hit counter
  localparam logic [PLEN-1:0] ADR_BP_COUNT = 8'd10;

  //////////////////////////////
  // enums
  //////////////////////////////

  // host commands
  typedef enum logic [2:0] {
    CMD_NOP     = 3'd0,
    CMD_STALL   = 3'd1,
    CMD_UNSTALL = 3'd2,
    CMD_READ    = 3'd3,
    CMD_WRITE   = 3'd4
  } dbg_cmd_e;

  // host controller fsm
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUS  = 2'd1,
    ST_RSP  = 2'd2
  } host_state_e;

endpackage

`default_nettype wire

/* dbg_bp_unit.sv */
/*
  Hardware breakpoint comparator. Flags a hit in the same cycle when the
  retiring pc equals the breakpoint address and the breakpoint is enabled,
  and keeps a wrapping count of hits.
*/

`default_nettype none

module dbg_bp_unit (
  input  wire                           clk,
  input  wire                           rstn,

  // cpu retire side
  input  wire  [dbg_pkg::XLEN-1:0]      pc_i,
  input  wire                           pc_valid_i,

  // settings from the register block
  input  wire  [dbg_pkg::XLEN-1:0]      bp_addr_i,
  input  wire                           bp_en_i,

  // hit pulse and count
  output logic                          bp_hit_o,
  output logic [dbg_pkg::XLEN-1:0]      bp_count_o
);

  //////////////////////////////
  // compare
  //////////////////////////////

  // combinational so the stall lands in the hit cycle
  assign bp_hit_o = pc_valid_i & bp_en_i & (pc_i == bp_addr_i);

  //////////////////////////////
  // hit counter
  //////////////////////////////

  // wraps at 2**XLEN
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_count_o <= '0;
    end else if (bp_hit_o) begin
      bp_count_o <= bp_count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* dbg_regs.sv */
/*
  CPU side debug register block. Answers each debug bus strobe with a one
  cycle ack and holds the shadow gpr bank, the breakpoint address and the
  breakpoint enable. The hit count from the comparator reads back here.
*/

`default_nettype none

module dbg_regs (
  input  wire                           clk,
  input  wire                           rstn,

  // debug bus slave
  input  wire                           dbg_stb_i,
  input  wire                           dbg_we_i,
  input  wire  [dbg_pkg::PLEN-1:0]      dbg_adr_i,
  input  wire  [dbg_pkg::XLEN-1:0]      dbg_wdat_i,
  output logic                          dbg_ack_o,
  output logic [dbg_pkg::XLEN-1:0]      dbg_rdat_o,

  // breakpoint settings and count
  input  wire  [dbg_pkg::XLEN-1:0]      bp_count_i,
  output logic [dbg_pkg::XLEN-1:0]      bp_addr_o,
  output logic                          bp_en_o
);

  logic [dbg_pkg::XLEN-1:0] gpr_q [dbg_pkg::NUM_GPR];
  logic [dbg_pkg::XLEN-1:0] rdat_d;
  logic                     is_gpr;
  logic                     access;

  // gpr window is the bottom of the map
  assign is_gpr = (dbg_adr_i < dbg_pkg::PLEN'(dbg_pkg::NUM_GPR));

  // new strobe seen, ack goes out next cycle
  assign access = dbg_stb_i & ~dbg_ack_o;

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    rdat_d = '0;
    if (is_gpr) begin
      rdat_d = gpr_q[dbg_adr_i[dbg_pkg::GPR_AW-1:0]];
    end else if (dbg_adr_i == dbg_pkg::ADR_BP_ADDR) begin
      rdat_d = bp_addr_o;
    end else if (dbg_adr_i == dbg_pkg::ADR_BP_CTRL) begin
      rdat_d = {{(dbg_pkg::XLEN-1){1'b0}}, bp_en_o};
    end else if (dbg_adr_i == dbg_pkg::ADR_BP_COUNT) begin
      rdat_d = bp_count_i;
    end
  end

  //////////////////////////////
  // ack and writes
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_ack_o  <= 1'b0;
      dbg_rdat_o <= '0;
      bp_addr_o  <= '0;
      bp_en_o    <= 1'b0;
      for (int i = 0; i < dbg_pkg::NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else begin
      dbg_ack_o <= access;
      if (access) begin
        // read data valid while ack is high
        dbg_rdat_o <= rdat_d;
        if (dbg_we_i) begin
          // count address and holes drop the write
          if (is_gpr) begin
            gpr_q[dbg_adr_i[dbg_pkg::GPR_AW-1:0]] <= dbg_wdat_i;
          end else if (dbg_adr_i == dbg_pkg::ADR_BP_ADDR) begin
            bp_addr_o <= dbg_wdat_i;
          end else if (dbg_adr_i == dbg_pkg::ADR_BP_CTRL) begin
            bp_en_o <= dbg_wdat_i[0];
          end
        end
      end
    end
  end

  // master must hold strobe through the ack cycle
  a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack_o |-> dbg_stb_i)
    else $error("debug ack without strobe");

endmodule

`default_nettype wire

/* dbg_host_ctrl.sv */
/*
  Host side debug controller. Takes one command at a time from the host,
  keeps the sticky CPU stall and runs single read or write cycles on the
  strobe/ack debug bus. Every accepted command gets one response pulse.
*/

`default_nettype none

module dbg_host_ctrl (
  input  wire                           clk,
  input  wire                           rstn,

  // host command port
  input  wire                           cmd_valid_i,
  input  dbg_pkg::dbg_cmd_e             cmd_i,
  input  wire  [dbg_pkg::PLEN-1:0]      cmd_addr_i,
  input  wire  [dbg_pkg::XLEN-1:0]      cmd_data_i,
  output logic                          busy_o,
  output logic                          rsp_valid_o,
  output logic [dbg_pkg::XLEN-1:0]      rsp_data_o,

  // breakpoint and cpu stall
  input  wire                           bp_hit_i,
  output logic                          cpu_stall_o,

  // debug bus master
  output logic                          dbg_stb_o,
  output logic                          dbg_we_o,
  output logic [dbg_pkg::PLEN-1:0]      dbg_adr_o,
  output logic [dbg_pkg::XLEN-1:0]      dbg_wdat_o,
  input  wire                           dbg_ack_i,
  input  wire  [dbg_pkg::XLEN-1:0]      dbg_rdat_i
);

  dbg_pkg::host_state_e state_q;
  logic                 busy_q;
  logic                 stall_q;
  logic                 accept;

  // new command only when nothing is in flight
  assign accept = cmd_valid_i & ~busy_q;

  //////////////////////////////
  // command fsm
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= dbg_pkg::ST_IDLE;
      busy_q   <= 1'b0;
      dbg_we_o <= 1'b0;
    end else begin
      case (state_q)
        dbg_pkg::ST_IDLE: begin
          if (accept) begin
            busy_q <= 1'b1;
            // bus commands go through ST_BUS, the rest answer right away
            if (cmd_i == dbg_pkg::CMD_READ || cmd_i == dbg_pkg::CMD_WRITE) begin
              state_q  <= dbg_pkg::ST_BUS;
              dbg_we_o <= (cmd_i == dbg_pkg::CMD_WRITE);
            end else begin
              state_q  <= dbg_pkg::ST_RSP;
            end
          end
        end
        dbg_pkg::ST_BUS: begin
          // strobe drops on the ack edge
          if (dbg_ack_i) begin
            state_q  <= dbg_pkg::ST_RSP;
            dbg_we_o <= 1'b0;
          end
        end
        dbg_pkg::ST_RSP: begin
          state_q <= dbg_pkg::ST_IDLE;
          busy_q  <= 1'b0;
        end
        default: begin
          state_q <= dbg_pkg::ST_IDLE;
          busy_q  <= 1'b0;
        end
      endcase
    end
  end

  // bus payload, latched with the command
  always_ff @(posedge clk) begin
    if (accept) begin
      dbg_adr_o  <= cmd_addr_i;
      dbg_wdat_o <= cmd_data_i;
    end
  end

  // response data, zero unless a read returns something
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data_o <= '0;
    end else if (state_q == dbg_pkg::ST_BUS && dbg_ack_i && !dbg_we_o) begin
      rsp_data_o <= dbg_rdat_i;
    end
  end

  assign dbg_stb_o   = (state_q == dbg_pkg::ST_BUS);
  assign rsp_valid_o = (state_q == dbg_pkg::ST_RSP);
  assign busy_o      = busy_q;

  //////////////////////////////
  // sticky stall
  //////////////////////////////

  // a hit beats an unstall in the same cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stall_q <= 1'b0;
    end else if (bp_hit_i) begin
      stall_q <= 1'b1;
    end else if (accept && cmd_i == dbg_pkg::CMD_STALL) begin
      stall_q <= 1'b1;
    end else if (accept && cmd_i == dbg_pkg::CMD_UNSTALL) begin
      stall_q <= 1'b0;
    end
  end

  // hit stalls the cpu in its own cycle
  assign cpu_stall_o = stall_q | bp_hit_i;

  //////////////////////////////
  // checks
  //////////////////////////////

  // strobe and address hold until the slave acks
  a_stb_hold: assert property (@(posedge clk) disable iff (!rstn)
    dbg_stb_o && !dbg_ack_i |=> dbg_stb_o && $stable(dbg_adr_o))
    else $error("debug strobe or address changed before ack");

  // busy flag tracks the fsm
  a_idle_not_busy: assert property (@(posedge clk) disable iff (!rstn)
    state_q == dbg_pkg::ST_IDLE |-> !busy_o)
    else $error("busy high while controller idle");

endmodule

`default_nettype wire

/* dbg_top.sv */
/*
  Debug unit top level. Connects the host controller, the debug register
  block and the breakpoint comparator to the host and CPU ports.
*/

`default_nettype none

module dbg_top (
  input  wire                           clk,
  input  wire                           rstn,

  // host command port
  input  wire                           cmd_valid_i,
  input  dbg_pkg::dbg_cmd_e             cmd_i,
  input  wire  [dbg_pkg::PLEN-1:0]      cmd_addr_i,
  input  wire  [dbg_pkg::XLEN-1:0]      cmd_data_i,
  output logic                          busy_o,
  output logic                          rsp_valid_o,
  output logic [dbg_pkg::XLEN-1:0]      rsp_data_o,

  // cpu side
  input  wire  [dbg_pkg::XLEN-1:0]      pc_i,
  input  wire                           pc_valid_i,
  output logic                          cpu_stall_o
);

  // debug bus
  logic                     dbg_stb;
  logic                     dbg_we;
  logic [dbg_pkg::PLEN-1:0] dbg_adr;
  logic [dbg_pkg::XLEN-1:0] dbg_wdat;
  logic                     dbg_ack;
  logic [dbg_pkg::XLEN-1:0] dbg_rdat;

  // breakpoint path
  logic [dbg_pkg::XLEN-1:0] bp_addr;
  logic                     bp_en;
  logic                     bp_hit;
  logic [dbg_pkg::XLEN-1:0] bp_count;

  dbg_host_ctrl u_host_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .bp_hit_i    (bp_hit),
    .cpu_stall_o (cpu_stall_o),
    .dbg_stb_o   (dbg_stb),
    .dbg_we_o    (dbg_we),
    .dbg_adr_o   (dbg_adr),
    .dbg_wdat_o  (dbg_wdat),
    .dbg_ack_i   (dbg_ack),
    .dbg_rdat_i  (dbg_rdat)
  );

  dbg_regs u_regs (
    .clk        (clk),
    .rstn       (rstn),
    .dbg_stb_i  (dbg_stb),
    .dbg_we_i   (dbg_we),
    .dbg_adr_i  (dbg_adr),
    .dbg_wdat_i (dbg_wdat),
    .dbg_ack_o  (dbg_ack),
    .dbg_rdat_o (dbg_rdat),
    .bp_count_i (bp_count),
    .bp_addr_o  (bp_addr),
    .bp_en_o    (bp_en)
  );

  dbg_bp_unit u_bp_unit (
    .clk        (clk),
    .rstn       (rstn),
    .pc_i       (pc_i),
    .pc_valid_i (pc_valid_i),
    .bp_addr_i  (bp_addr),
    .bp_en_i    (bp_en),
    .bp_hit_o   (bp_hit),
    .bp_count_o (bp_count)
  );

endmodule

`default_nettype wire

/* tb_dbg_top.sv */
/*
  Self-checking testbench for the debug unit. Drives host commands and a
  random CPU pc stream into dbg_top, keeps a reference model of the debug
  registers, stall and hit count, and checks every response and stall level.
*/

`default_nettype none

module tb_dbg_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  // host commands in the sequence, cpu windows counted as commands
  localparam int NUM_CMDS     = 64;
  localparam int WDOG_CYCLES  = NUM_CMDS * 10 + RESET_CYCLES;

  logic                       clk;
  logic                       rstn;
  logic                       cmd_valid_i;
  dbg_pkg::dbg_cmd_e          cmd_i;
  logic [dbg_pkg::PLEN-1:0]   cmd_addr_i;
  logic [dbg_pkg::XLEN-1:0]   cmd_data_i;
  logic                       busy_o;
  logic                       rsp_valid_o;
  logic [dbg_pkg::XLEN-1:0]   rsp_data_o;
  logic [dbg_pkg::XLEN-1:0]   pc_i;
  logic                       pc_valid_i;
  logic                       cpu_stall_o;

  // reference model
  logic [dbg_pkg::XLEN-1:0]   shadow [dbg_pkg::NUM_GPR];
  logic [dbg_pkg::XLEN-1:0]   model_bp_addr;
  logic                       model_bp_en;
  logic [dbg_pkg::XLEN-1:0]   model_count;
  logic                       exp_stall;
  logic [dbg_pkg::XLEN-1:0]   exp_rsp_q [$];

  logic [31:0]                lfsr_q;
  logic                       cpu_run;
  int                         mismatch_cnt;
  int                         fail_cnt;
  int                         check_cnt;
  int                         cmd_cnt;
  int                         rsp_cnt;

  dbg_top u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .pc_i        (pc_i),
    .pc_valid_i  (pc_valid_i),
    .cpu_stall_o (cpu_stall_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // expected read data from the model
  function automatic logic [dbg_pkg::XLEN-1:0] ref_read(input logic [dbg_pkg::PLEN-1:0] adr);
    if (adr < 8'(dbg_pkg::NUM_GPR)) begin
      return shadow[adr[dbg_pkg::GPR_AW-1:0]];
    end
    case (adr)
      dbg_pkg::ADR_BP_ADDR:  return model_bp_addr;
      dbg_pkg::ADR_BP_CTRL:  return {31'b0, model_bp_en};
      dbg_pkg::ADR_BP_COUNT: return model_count;
      default:               return '0;
    endcase
  endfunction

  // count address and holes drop the write
  task automatic model_write(input logic [dbg_pkg::PLEN-1:0] adr,
                             input logic [dbg_pkg::XLEN-1:0] data);
    if (adr < 8'(dbg_pkg::NUM_GPR)) begin
      shadow[adr[dbg_pkg::GPR_AW-1:0]] = data;
    end else if (adr == dbg_pkg::ADR_BP_ADDR) begin
      model_bp_addr = data;
    end else if (adr == dbg_pkg::ADR_BP_CTRL) begin
      model_bp_en = data[0];
    end
  endtask

  task automatic check(input string name, input logic [dbg_pkg::XLEN-1:0] got,
                       input logic [dbg_pkg::XLEN-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_fail(input string msg);
    fail_cnt++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  // one host command, optionally with a second pulse while busy
  task automatic host_cmd(input dbg_pkg::dbg_cmd_e cmd, input logic [dbg_pkg::PLEN-1:0] adr,
                          input logic [dbg_pkg::XLEN-1:0] data, input bit overlap);
    int n;
    n           = 0;
    cmd_valid_i = 1'b1;
    cmd_i       = cmd;
    cmd_addr_i  = adr;
    cmd_data_i  = data;
    cmd_cnt++;
    if (cmd == dbg_pkg::CMD_READ) begin
      exp_rsp_q.push_back(ref_read(adr));
    end else begin
      exp_rsp_q.push_back('0);
    end
    if (cmd == dbg_pkg::CMD_WRITE) begin
      model_write(adr, data);
    end
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b0;
    // stall register moved at the accepting edge
    if (cmd == dbg_pkg::CMD_STALL) begin
      exp_stall = 1'b1;
    end else if (cmd == dbg_pkg::CMD_UNSTALL) begin
      exp_stall = 1'b0;
    end
    if (overlap) begin
      // must be ignored, busy is high
      check("busy_o", 32'(busy_o), 32'd1);
      cmd_valid_i = 1'b1;
      cmd_i       = dbg_pkg::CMD_WRITE;
      cmd_data_i  = ~data;
      @(posedge clk);
      #2;
      cmd_valid_i = 1'b0;
    end
    while (!rsp_valid_o && n < 10) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!rsp_valid_o) begin
      report_fail("no response pulse after host command");
    end
    @(posedge clk);
    #2;
  endtask

  // let the cpu retire pcs for n cycles
  task automatic run_cpu(input int n);
    @(negedge clk);
    cpu_run = 1'b1;
    repeat (n) @(negedge clk);
    cpu_run = 1'b0;
    @(posedge clk);
    #2;
  endtask

  //////////////////////////////
  // cpu and compare processes
  //////////////////////////////

  // no retire while stalled, bp address on about half the cycles
  always begin
    @(posedge clk);
    #2;
    if (cpu_run && !cpu_stall_o) begin
      pc_valid_i = 1'b1;
      if (rand_bits(1) == 32'd1) begin
        pc_i = model_bp_addr;
      end else begin
        pc_i = rand_bits(32);
      end
      if (model_bp_en && pc_i == model_bp_addr) begin
        model_count++;
        exp_stall = 1'b1;
      end
    end else begin
      pc_valid_i = 1'b0;
    end
  end

  // mid cycle, outputs are settled
  always @(negedge clk) begin
    if (rstn) begin
      check("cpu_stall_o", 32'(cpu_stall_o), 32'(exp_stall));
      if (rsp_valid_o) begin
        rsp_cnt++;
        if (exp_rsp_q.size() == 0) begin
          report_fail("response pulse with no command outstanding");
        end else begin
          check("rsp_data_o", rsp_data_o, exp_rsp_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    report_fail("watchdog expired before the test sequence finished");
    $display("mismatches %0d, other errors %0d", mismatch_cnt, fail_cnt);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [dbg_pkg::PLEN-1:0] adr;
    logic [dbg_pkg::XLEN-1:0] data;
    clk = 1'b0;
    rstn = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = dbg_pkg::CMD_NOP;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    pc_i = '0;
    pc_valid_i = 1'b0;
    lfsr_q = 32'd89506;
    cpu_run = 1'b0;
    model_bp_addr = '0;
    model_bp_en = 1'b0;
    model_count = '0;
    exp_stall = 1'b0;
    mismatch_cnt = 0;
    fail_cnt = 0;
    check_cnt = 0;
    cmd_cnt = 0;
    rsp_cnt = 0;
    for (int i = 0; i < dbg_pkg::NUM_GPR; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(posedge clk);
    #2;

    // shadow bank, last write wins
    for (int i = 0; i < dbg_pkg::NUM_GPR; i++) begin
      data = rand_bits(32);
      host_cmd(dbg_pkg::CMD_WRITE, 8'(i), data, 1'b0);
    end
    repeat (12) begin
      adr  = 8'(rand_bits(3));
      data = rand_bits(32);
      host_cmd(dbg_pkg::CMD_WRITE, adr, data, 1'b0);
    end
    for (int i = 0; i < dbg_pkg::NUM_GPR; i++) begin
      host_cmd(dbg_pkg::CMD_READ, 8'(i), '0, 1'b0);
    end

    // holes, read-only count, one bit ctrl
    host_cmd(dbg_pkg::CMD_WRITE, 8'd11, 32'hdead_beef, 1'b0);
    host_cmd(dbg_pkg::CMD_READ, 8'd11, '0, 1'b0);
    adr = 8'(rand_bits(8)) | 8'h10;
    host_cmd(dbg_pkg::CMD_READ, adr, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_COUNT, rand_bits(32), 1'b0);
    host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_COUNT, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_CTRL, 32'hffff_fffe, 1'b0);
    host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_CTRL, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_CTRL, 32'hffff_ffff, 1'b0);
    host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_CTRL, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_CTRL, '0, 1'b0);

    // host stall and release, cpu held off meanwhile
    host_cmd(dbg_pkg::CMD_STALL, '0, '0, 1'b0);
    run_cpu(6);
    host_cmd(dbg_pkg::CMD_NOP, '0, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_UNSTALL, '0, '0, 1'b0);

    // enabled breakpoint, sticky stall and hit count
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_ADDR, rand_bits(32), 1'b0);
    host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_ADDR, '0, 1'b0);
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_CTRL, 32'd1, 1'b0);
    repeat (3) begin
      run_cpu(16);
      if (!exp_stall) begin
        report_fail("cpu window ended without a breakpoint hit");
      end
      host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_COUNT, '0, 1'b0);
      host_cmd(dbg_pkg::CMD_UNSTALL, '0, '0, 1'b0);
    end

    // disabled breakpoint, no stall and no count
    host_cmd(dbg_pkg::CMD_WRITE, dbg_pkg::ADR_BP_CTRL, '0, 1'b0);
    run_cpu(16);
    host_cmd(dbg_pkg::CMD_READ, dbg_pkg::ADR_BP_COUNT, '0, 1'b0);

    // second pulse during busy is dropped
    data = rand_bits(32);
    host_cmd(dbg_pkg::CMD_WRITE, 8'd3, data, 1'b1);
    host_cmd(dbg_pkg::CMD_READ, 8'd3, '0, 1'b1);
    host_cmd(dbg_pkg::CMD_READ, 8'd3, '0, 1'b0);

    repeat (2) @(posedge clk);
    check("pending responses", 32'(exp_rsp_q.size()), '0);
    check("response count", 32'(rsp_cnt), 32'(cmd_cnt));
    $display("mismatches %0d, other errors %0d, checks %0d", mismatch_cnt, fail_cnt,
             check_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
dbg_pkg.sv
dbg_bp_unit.sv
dbg_regs.sv
dbg_host_ctrl.sv
dbg_top.sv
tb_dbg_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_dbg_top
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
